/* design/cpu_reg_pkg.sv */
`default_nettype none

//////////////////////////////////////////////////
// CPU side register map
//////////////////////////////////////////////////

package cpu_reg_pkg;

	// register addresses on cpu_addr
	localparam logic [2:0] REG_PRIO_A = 3'd1;
	localparam logic [2:0] REG_PRIO_B = 3'd5;

	// both layers start at the lowest priority
	localparam logic [2:0] PRIO_A_RESET = 3'd0;
	localparam logic [2:0] PRIO_B_RESET = 3'd0;

	// write port handshake states
	localparam logic ST_IDLE = 1'b0;
	localparam logic ST_ACK = 1'b1;

	//////////////////////////////////////////////////
	// shared 8-bit bus
	//////////////////////////////////////////////////

	// same byte seen as tile attribute during fetch
	// or as a priority command during a CPU write
	typedef union packed {
		logic [7:0] attr;
		struct packed {
			// upper nibble unused by the priority latch
			logic [3:0] spare;
			// priority rides on bits 3..1
			logic [2:0] prio;
			logic       ignored;
		} prio_cmd;
	} mdi_word_u;

endpackage

`default_nettype wire

/* design/layer_mixer.sv */
`timescale 1ns/1ns
`default_nettype none

module layer_mixer
	import tile_pkg::*;
(
	input  wire              CLK_6M,
	input  wire              rst,
	input  wire [PRIO_W-1:0] pr_a,
	input  wire [PRIO_W-1:0] pr_b,
	input  wire [ATTR_W-1:0] color_a,
	input  wire [PIX_W-1:0]  pixel_a,
	input  wire [ATTR_W-1:0] color_b,
	input  wire [PIX_W-1:0]  pixel_b,
	input  wire [PRIO_W-1:0] pri,
	input  wire [ATTR_W-1:0] cli,
	input  wire [PIX_W-1:0]  dti,
	output logic [PRIO_W-1:0] pro,
	output logic [ATTR_W-1:0] clo,
	output logic [PIX_W-1:0]  dto
);

	//////////////////////////////////////////////////
	// candidate qualification
	//////////////////////////////////////////////////

	logic a_win;
	logic b_win;
	logic sel_b;

	// opaque and strictly above the upstream chip
	assign a_win = (pixel_a != PIX_TRANSPARENT) && (pr_a > pri);
	assign b_win = (pixel_b != PIX_TRANSPARENT) && (pr_b > pri);

	// A keeps equal priority
	assign sel_b = b_win && (!a_win || (pr_b > pr_a));

	//////////////////////////////////////////////////
	// winner select
	//////////////////////////////////////////////////

	logic [PRIO_W-1:0] pr_w;
	logic [ATTR_W-1:0] cl_w;
	logic [PIX_W-1:0]  dt_w;

	always_comb begin
		// cascade passes unless a layer beats it
		pr_w = pri;
		cl_w = cli;
		dt_w = dti;
		if (sel_b) begin
			pr_w = pr_b;
			cl_w = color_b;
			dt_w = pixel_b;
		end else if (a_win) begin
			pr_w = pr_a;
			cl_w = color_a;
			dt_w = pixel_a;
		end
	end

	// one pipeline stage to the downstream chip
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			pro <= '0;
			clo <= '0;
			dto <= '0;
		end else begin
			pro <= pr_w;
			clo <= cl_w;
			dto <= dt_w;
		end
	end

endmodule

`default_nettype wire

/* design/layer_shifter.sv */
`timescale 1ns/1ns
`default_nettype none

module layer_shifter
	import tile_pkg::*;
(
	input  wire              CLK_6M,
	input  wire              rst,
	input  wire              load,
	input  wire              flip,
	input  wire [ATTR_W-1:0] attr_in,
	input  wire [GDI_W-1:0]  planes_in,
	output logic [ATTR_W-1:0] color,
	output logic [PIX_W-1:0]  pixel
);

	//////////////////////////////////////////////////
	// plane shift registers
	//////////////////////////////////////////////////

	logic [ATTR_W-1:0]  attr_q;
	logic [PLANE_W-1:0] p0;
	logic [PLANE_W-1:0] p1;
	logic [PLANE_W-1:0] p2;

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			// all ones reads as transparent
			attr_q <= '0;
			p0     <= '1;
			p1     <= '1;
			p2     <= '1;
		end else if (load) begin
			attr_q <= attr_in;
			p0     <= planes_in[PLANE0_LSB +: PLANE_W];
			p1     <= planes_in[PLANE1_LSB +: PLANE_W];
			p2     <= planes_in[PLANE2_LSB +: PLANE_W];
		end else if (flip) begin
			// mirrored screen, drain from bit 0
			p0 <= {1'b1, p0[PLANE_W-1:1]};
			p1 <= {1'b1, p1[PLANE_W-1:1]};
			p2 <= {1'b1, p2[PLANE_W-1:1]};
		end else begin
			// fill with ones so a drained layer goes transparent
			p0 <= {p0[PLANE_W-2:0], 1'b1};
			p1 <= {p1[PLANE_W-2:0], 1'b1};
			p2 <= {p2[PLANE_W-2:0], 1'b1};
		end
	end

	//////////////////////////////////////////////////
	// pixel assembly
	//////////////////////////////////////////////////

	// output end of the shifters
	logic [$clog2(PLANE_W)-1:0] tap;

	assign tap   = flip ? '0 : '1;
	assign pixel = {p2[tap], p1[tap], p0[tap]};
	assign color = attr_q;

endmodule

`default_nettype wire

/* design/prio_reg_port.sv */
`timescale 1ns/1ns
`default_nettype none

module prio_reg_port
	import tile_pkg::*;
	import cpu_reg_pkg::*;
(
	input  wire              CLK_6M,
	input  wire              rst,
	input  wire              cpu_req,
	input  wire [2:0]        cpu_addr,
	input  wire mdi_word_u   mdi,
	output logic             cpu_ack,
	output logic [PRIO_W-1:0] pr_a,
	output logic [PRIO_W-1:0] pr_b
);

	//////////////////////////////////////////////////
	// address decode
	//////////////////////////////////////////////////

	logic hit_a;
	logic hit_b;

	assign hit_a = (cpu_addr == REG_PRIO_A);
	assign hit_b = (cpu_addr == REG_PRIO_B);

	//////////////////////////////////////////////////
	// four-phase handshake FSM
	//////////////////////////////////////////////////

	// idle waits for req, ack waits for req to drop
	logic state;

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			state <= ST_IDLE;
			pr_a  <= PRIO_A_RESET;
			pr_b  <= PRIO_B_RESET;
		end else begin
			case (state)
				ST_IDLE: begin
					// write happens on the same edge that raises ack
					if (cpu_req) begin
						if (hit_a) begin
							pr_a <= mdi.prio_cmd.prio;
						end
						if (hit_b) begin
							pr_b <= mdi.prio_cmd.prio;
						end
						// unmatched address still gets acked
						state <= ST_ACK;
					end
				end
				ST_ACK: begin
					// req still high means same request, no second write
					if (!cpu_req) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// ack is the state bit itself
	assign cpu_ack = (state == ST_ACK);

endmodule

`default_nettype wire

/* design/tile_fetch_latch.sv */
`timescale 1ns/1ns
`default_nettype none

module tile_fetch_latch
	import tile_pkg::*;
	import cpu_reg_pkg::*;
(
	input  wire              CLK_6M,
	input  wire              rst,
	input  wire              clk_2h,
	input  wire mdi_word_u   mdi,
	input  wire [GDI_W-1:0]  gdi,
	output logic [ATTR_W-1:0] attr_a,
	output logic [ATTR_W-1:0] attr_b,
	output logic [GDI_W-1:0]  planes_a,
	output logic [GDI_W-1:0]  planes_b
);

	//////////////////////////////////////////////////
	// 2H phase edge detect
	//////////////////////////////////////////////////

	// 2H sampled as data, one 6M cycle behind
	logic clk_2h_d;
	logic fall_2h;
	logic rise_2h;

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			clk_2h_d <= 1'b0;
		end else begin
			clk_2h_d <= clk_2h;
		end
	end

	// high then low
	assign fall_2h = clk_2h_d & ~clk_2h;
	// low then high
	assign rise_2h = ~clk_2h_d & clk_2h;

	//////////////////////////////////////////////////
	// crossed fetch slots
	//////////////////////////////////////////////////

	// the attribute and the graphics word of a layer
	// arrive in opposite half-lines of 2H
	always_ff @(posedge CLK_6M) begin
		// falling half-line
		if (fall_2h) begin
			attr_a   <= mdi.attr;
			planes_b <= gdi;
		end
		// rising half-line
		if (rise_2h) begin
			attr_b   <= mdi.attr;
			planes_a <= gdi;
		end
	end

endmodule

`default_nettype wire

/* design/tile_pkg.sv */
`default_nettype none

//////////////////////////////////////////////////
// tile pixel and bitplane geometry
//////////////////////////////////////////////////

package tile_pkg;

	// one pixel code is three bitplanes deep
	localparam int PIX_W = 3;

	// pixels held in one plane slice
	localparam int PLANE_W = 4;

	// graphics ROM word carries all three planes
	localparam int GDI_W = 12;

	// layer and cascade priority width
	localparam int PRIO_W = 3;

	// color attribute byte from the tile RAM
	localparam int ATTR_W = 8;

	//////////////////////////////////////////////////
	// pixel encoding
	//////////////////////////////////////////////////

	// all planes set means see-through
	localparam logic [PIX_W-1:0] PIX_TRANSPARENT = 3'd7;

	//////////////////////////////////////////////////
	// plane positions in the graphics word
	//////////////////////////////////////////////////

	// plane 0 is the pixel lsb
	localparam int PLANE0_LSB = 0;
	localparam int PLANE1_LSB = 4;
	// plane 2 is the pixel msb
	localparam int PLANE2_LSB = 8;

endpackage

`default_nettype wire

/* design/tilemap_pair.sv */
`timescale 1ns/1ns
`default_nettype none

module tilemap_pair
	import tile_pkg::*;
	import cpu_reg_pkg::*;
(
	input  wire              CLK_6M,
	input  wire              rst,
	input  wire mdi_word_u   mdi,
	input  wire [GDI_W-1:0]  gdi,
	input  wire              clk_2h,
	input  wire              ha2,
	input  wire              hb2,
	input  wire              flip,
	input  wire [PRIO_W-1:0] pri,
	input  wire [ATTR_W-1:0] cli,
	input  wire [PIX_W-1:0]  dti,
	input  wire              cpu_req,
	input  wire [2:0]        cpu_addr,
	output logic             cpu_ack,
	output logic [PRIO_W-1:0] pro,
	output logic [ATTR_W-1:0] clo,
	output logic [PIX_W-1:0]  dto
);

	// fetch latch to shifters
	logic [ATTR_W-1:0] attr_a;
	logic [ATTR_W-1:0] attr_b;
	logic [GDI_W-1:0]  planes_a;
	logic [GDI_W-1:0]  planes_b;

	// priority registers
	logic [PRIO_W-1:0] pr_a;
	logic [PRIO_W-1:0] pr_b;

	// shifter pixels into the mixer
	logic [ATTR_W-1:0] color_a;
	logic [PIX_W-1:0]  pixel_a;
	logic [ATTR_W-1:0] color_b;
	logic [PIX_W-1:0]  pixel_b;

	//////////////////////////////////////////////////
	// input side
	//////////////////////////////////////////////////

	tile_fetch_latch u_fetch (
		.CLK_6M   (CLK_6M),
		.rst      (rst),
		.clk_2h   (clk_2h),
		.mdi      (mdi),
		.gdi      (gdi),
		.attr_a   (attr_a),
		.attr_b   (attr_b),
		.planes_a (planes_a),
		.planes_b (planes_b)
	);

	prio_reg_port u_prio (
		.CLK_6M   (CLK_6M),
		.rst      (rst),
		.cpu_req  (cpu_req),
		.cpu_addr (cpu_addr),
		.mdi      (mdi),
		.cpu_ack  (cpu_ack),
		.pr_a     (pr_a),
		.pr_b     (pr_b)
	);

	//////////////////////////////////////////////////
	// per-layer shifters
	//////////////////////////////////////////////////

	layer_shifter shift_a (
		.CLK_6M    (CLK_6M),
		.rst       (rst),
		.load      (ha2),
		.flip      (flip),
		.attr_in   (attr_a),
		.planes_in (planes_a),
		.color     (color_a),
		.pixel     (pixel_a)
	);

	layer_shifter shift_b (
		.CLK_6M    (CLK_6M),
		.rst       (rst),
		.load      (hb2),
		.flip      (flip),
		.attr_in   (attr_b),
		.planes_in (planes_b),
		.color     (color_b),
		.pixel     (pixel_b)
	);

	//////////////////////////////////////////////////
	// output side
	//////////////////////////////////////////////////

	layer_mixer u_mix (
		.CLK_6M  (CLK_6M),
		.rst     (rst),
		.pr_a    (pr_a),
		.pr_b    (pr_b),
		.color_a (color_a),
		.pixel_a (pixel_a),
		.color_b (color_b),
		.pixel_b (pixel_b),
		.pri     (pri),
		.cli     (cli),
		.dti     (dti),
		.pro     (pro),
		.clo     (clo),
		.dto     (dto)
	);

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
design/tile_pkg.sv
design/cpu_reg_pkg.sv
design/tile_fetch_latch.sv
design/prio_reg_port.sv
design/layer_shifter.sv
design/layer_mixer.sv
design/tilemap_pair.sv
verif/tilemap_pair_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the tilemap_pair testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module tilemap_pair_tb -o tilemap_pair_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tilemap_pair_sim > sim.log 2>&1 || echo "simulator returned an error" >> sim.log
cat sim.log

grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "no result in sim.log"; exit 1; }
exit 0

/* include/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

//////////////////////////////////////////////////
// reference model
//////////////////////////////////////////////////

// four pixels in screen order with pixel k at [k*PIX_W +: PIX_W]
function automatic logic [PLANE_W*PIX_W-1:0] expected_pixels(
	input logic [GDI_W-1:0] planes,
	input logic             flip
);
	logic [PLANE_W*PIX_W-1:0] seq;
	int b;
	seq = '0;
	for (int k = 0; k < PLANE_W; k++) begin
		// unflipped drains from bit 3
		b = flip ? k : PLANE_W - 1 - k;
		seq[k*PIX_W +: PIX_W] = {planes[PLANE2_LSB + b], planes[PLANE1_LSB + b],
			planes[PLANE0_LSB + b]};
	end
	return seq;
endfunction

// winner packed as {pro, clo, dto}
function automatic logic [PRIO_W+ATTR_W+PIX_W-1:0] mix_winner(
	input logic [PRIO_W-1:0] pr_a,
	input logic [ATTR_W-1:0] col_a,
	input logic [PIX_W-1:0]  pix_a,
	input logic [PRIO_W-1:0] pr_b,
	input logic [ATTR_W-1:0] col_b,
	input logic [PIX_W-1:0]  pix_b,
	input logic [PRIO_W-1:0] pri,
	input logic [ATTR_W-1:0] cli,
	input logic [PIX_W-1:0]  dti
);
	logic a_ok;
	logic b_ok;
	a_ok = (pix_a != PIX_TRANSPARENT) && (pr_a > pri);
	b_ok = (pix_b != PIX_TRANSPARENT) && (pr_b > pri);
	if (b_ok && (!a_ok || pr_b > pr_a)) begin
		return {pr_b, col_b, pix_b};
	end
	if (a_ok) begin
		return {pr_a, col_a, pix_a};
	end
	return {pri, cli, dti};
endfunction

// full four-phase CPU write on cpu_req, cpu_addr and mdi
task automatic cpu_write(input logic [2:0] addr, input logic [7:0] data);
	int n;
	n = 0;
	@(posedge CLK_6M);
	#10;
	cpu_addr = addr;
	mdi      = data;
	cpu_req  = 1'b1;
	while (!cpu_ack && n < 4) begin
		@(posedge CLK_6M);
		#10;
		n++;
	end
	if (!cpu_ack) begin
		$display("ERROR %s: write to addr %0d expected cpu_ack 1, actual %0b",
			test_name, addr, cpu_ack);
		err_cnt++;
	end
	cpu_req = 1'b0;
	n = 0;
	while (cpu_ack && n < 4) begin
		@(posedge CLK_6M);
		#10;
		n++;
	end
	if (cpu_ack) begin
		$display("ERROR %s: write to addr %0d expected cpu_ack 0, actual %0b",
			test_name, addr, cpu_ack);
		err_cnt++;
	end
endtask

`endif

/* verif/tilemap_pair_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module tilemap_pair_tb
	import tile_pkg::*;
	import cpu_reg_pkg::*;
();

	// roughly three times the cycles the tests use
	localparam int MAX_CYCLES = 400;

	//////////////////////////////////////////////////
	// DUT side signals
	//////////////////////////////////////////////////

	logic              CLK_6M;
	logic              rst;
	logic [7:0]        mdi;
	logic [GDI_W-1:0]  gdi;
	logic              clk_2h;
	logic              ha2;
	logic              hb2;
	logic              flip;
	logic [PRIO_W-1:0] pri;
	logic [ATTR_W-1:0] cli;
	logic [PIX_W-1:0]  dti;
	logic              cpu_req;
	logic [2:0]        cpu_addr;
	wire               cpu_ack;
	wire [PRIO_W-1:0]  pro;
	wire [ATTR_W-1:0]  clo;
	wire [PIX_W-1:0]   dto;

	// bookkeeping
	int    err_cnt;
	int    err_base;
	int    tests_run;
	int    tests_failed;
	int    cycle_cnt;
	string test_name;

	// priorities as last written by the CPU
	logic [PRIO_W-1:0] exp_pr_a;
	logic [PRIO_W-1:0] exp_pr_b;

	// expected outputs armed by chk_en
	logic              chk_en;
	logic              reset_chk;
	logic [PRIO_W-1:0] exp_pro;
	logic [ATTR_W-1:0] exp_clo;
	logic [PIX_W-1:0]  exp_dto;

	// mid-cycle copies for error lines
	logic [PRIO_W-1:0] pro_mid;
	logic [ATTR_W-1:0] clo_mid;
	logic [PIX_W-1:0]  dto_mid;
	logic              ack_mid;

	`include "tb_model.svh"

	tilemap_pair dut0 (
		.CLK_6M   (CLK_6M),
		.rst      (rst),
		.mdi      (mdi),
		.gdi      (gdi),
		.clk_2h   (clk_2h),
		.ha2      (ha2),
		.hb2      (hb2),
		.flip     (flip),
		.pri      (pri),
		.cli      (cli),
		.dti      (dti),
		.cpu_req  (cpu_req),
		.cpu_addr (cpu_addr),
		.cpu_ack  (cpu_ack),
		.pro      (pro),
		.clo      (clo),
		.dto      (dto)
	);

	//////////////////////////////////////////////////
	// clock, watchdog, snapshots
	//////////////////////////////////////////////////

	// 6M pixel clock with a 100 ns period
	initial begin
		CLK_6M = 1'b0;
		forever #50 CLK_6M = ~CLK_6M;
	end

	always @(posedge CLK_6M) begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: run still going after %0d cycles", MAX_CYCLES);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// outputs are stable by the falling edge
	always @(negedge CLK_6M) begin
		pro_mid = pro;
		clo_mid = clo;
		dto_mid = dto;
		ack_mid = cpu_ack;
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	a_reset_zero: assert property (@(posedge CLK_6M)
		reset_chk |-> (pro == '0 && clo == '0 && dto == '0 && !cpu_ack))
	else begin
		$display("ERROR reset: expected pro 0 clo 0 dto 0 cpu_ack 0, actual %0d %0d %0d %0b",
			pro_mid, clo_mid, dto_mid, ack_mid);
		err_cnt++;
	end

	a_ack_needs_req: assert property (@(posedge CLK_6M) disable iff (rst)
		$rose(cpu_ack) |-> $past(cpu_req))
	else begin
		$display("ERROR %s: cpu_ack rose with no CPU request pending", test_name);
		err_cnt++;
	end

	// ack has to clear one edge after req drops
	a_ack_drops: assert property (@(posedge CLK_6M) disable iff (rst)
		(cpu_ack && !cpu_req) |=> !cpu_ack)
	else begin
		$display("ERROR %s: cpu_ack stayed high after cpu_req was released", test_name);
		err_cnt++;
	end

	a_out_pro: assert property (@(posedge CLK_6M) chk_en |-> pro == exp_pro)
	else begin
		$display("ERROR %s: expected pro %0d, actual %0d", test_name, exp_pro, pro_mid);
		err_cnt++;
	end

	a_out_clo: assert property (@(posedge CLK_6M) chk_en |-> clo == exp_clo)
	else begin
		$display("ERROR %s: expected clo %02h, actual %02h", test_name, exp_clo, clo_mid);
		err_cnt++;
	end

	a_out_dto: assert property (@(posedge CLK_6M) chk_en |-> dto == exp_dto)
	else begin
		$display("ERROR %s: expected dto %0d, actual %0d", test_name, exp_dto, dto_mid);
		err_cnt++;
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	// drive point just after the rising edge
	task automatic step();
		@(posedge CLK_6M);
		#10;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		err_base  = err_cnt;
	endtask

	task automatic end_test();
		int errs;
		errs = err_cnt - err_base;
		tests_run++;
		if (errs != 0) begin
			tests_failed++;
		end
		$display("test %s: %s, %0d errors", test_name, (errs == 0) ? "ok" : "failed", errs);
	endtask

	// priority sits on bits 3..1 of the bus
	function automatic logic [7:0] prio_byte(input logic [PRIO_W-1:0] p);
		return {4'h0, p, 1'b0};
	endfunction

	// fetch one tile over both 2H half-lines, load it, check four pixels
	task automatic run_tile(
		input logic [ATTR_W-1:0] at_a,
		input logic [GDI_W-1:0]  pl_a,
		input logic [ATTR_W-1:0] at_b,
		input logic [GDI_W-1:0]  pl_b,
		input logic              ld_b,
		input logic              vary_casc,
		input logic [PRIO_W-1:0] pri_min
	);
		logic [PLANE_W*PIX_W-1:0]       seq_a;
		logic [PLANE_W*PIX_W-1:0]       seq_b;
		logic [PRIO_W+ATTR_W+PIX_W-1:0] want;
		seq_a = expected_pixels(pl_a, flip);
		// an unloaded layer has drained to all ones
		seq_b = ld_b ? expected_pixels(pl_b, flip) : {PLANE_W{PIX_TRANSPARENT}};
		// rising half-line carries A planes and B attribute
		step();
		clk_2h = 1'b1;
		gdi    = pl_a;
		mdi    = at_b;
		// falling half-line carries A attribute and B planes
		step();
		clk_2h = 1'b0;
		mdi    = at_a;
		gdi    = pl_b;
		step();
		ha2 = 1'b1;
		hb2 = ld_b;
		// first pixel now on the shifter output
		step();
		ha2 = 1'b0;
		hb2 = 1'b0;
		for (int k = 0; k < PLANE_W; k++) begin
			if (vary_casc) begin
				pri = PRIO_W'($urandom_range(7, pri_min));
				cli = ATTR_W'($urandom);
				dti = PIX_W'($urandom);
			end
			want = mix_winner(exp_pr_a, at_a, seq_a[k*PIX_W +: PIX_W],
				exp_pr_b, at_b, seq_b[k*PIX_W +: PIX_W], pri, cli, dti);
			// mixer registers on this edge and the check follows on the next
			step();
			{exp_pro, exp_clo, exp_dto} = want;
			chk_en = 1'b1;
		end
		step();
		chk_en = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial begin
		void'($urandom(32'hcad4_8d76));
		rst          = 1'b1;
		mdi          = '0;
		gdi          = '0;
		clk_2h       = 1'b0;
		ha2          = 1'b0;
		hb2          = 1'b0;
		flip         = 1'b0;
		pri          = '0;
		cli          = '0;
		dti          = '0;
		cpu_req      = 1'b0;
		cpu_addr     = '0;
		chk_en       = 1'b0;
		reset_chk    = 1'b0;
		exp_pro      = '0;
		exp_clo      = '0;
		exp_dto      = '0;
		err_cnt      = 0;
		err_base     = 0;
		tests_run    = 0;
		tests_failed = 0;
		cycle_cnt    = 0;
		exp_pr_a     = PRIO_A_RESET;
		exp_pr_b     = PRIO_B_RESET;
		test_name    = "init";

		// reset for 4 edges and watched through the first free cycle
		begin_test("reset");
		step();
		reset_chk = 1'b1;
		repeat (3) step();
		rst = 1'b0;
		repeat (2) step();
		reset_chk = 1'b0;
		end_test();

		// two writes and then a stray address that must not touch A or B
		// both layers opaque so a stray 7 in either register shows on pro
		begin_test("handshake");
		cpu_write(REG_PRIO_A, prio_byte(3'd2));
		exp_pr_a = 3'd2;
		cpu_write(REG_PRIO_B, prio_byte(3'd3));
		exp_pr_b = 3'd3;
		cpu_write(3'd3, 8'hfe);
		run_tile(8'h5c, 12'h0f0, 8'ha3, 12'h0f0, 1'b1, 1'b0, 3'd0);
		end_test();

		// layer A alone over a zero-priority cascade
		begin_test("pixel_order");
		cli = 8'h11;
		dti = 3'd5;
		for (int f = 0; f < 2; f++) begin
			flip = f[0];
			repeat (3) begin
				run_tile(ATTR_W'($urandom), GDI_W'($urandom), 8'h00, 12'h000,
					1'b0, 1'b0, 3'd0);
			end
		end
		flip = 1'b0;
		end_test();

		// see-through A and then A at or below pri
		begin_test("cascade");
		run_tile(ATTR_W'($urandom), 12'hfff, 8'h00, 12'h000, 1'b0, 1'b1, 3'd0);
		run_tile(ATTR_W'($urandom), 12'h000, 8'h00, 12'h000, 1'b0, 1'b1, exp_pr_a);
		pri = '0;
		cli = '0;
		dti = '0;
		end_test();

		// both opaque with B above A and then B equal to A
		begin_test("layer_order");
		cpu_write(REG_PRIO_A, prio_byte(3'd3));
		exp_pr_a = 3'd3;
		cpu_write(REG_PRIO_B, prio_byte(3'd5));
		exp_pr_b = 3'd5;
		run_tile(ATTR_W'($urandom), 12'h000, ATTR_W'($urandom), 12'h00f,
			1'b1, 1'b0, 3'd0);
		cpu_write(REG_PRIO_B, prio_byte(3'd3));
		exp_pr_b = 3'd3;
		run_tile(ATTR_W'($urandom), 12'h000, ATTR_W'($urandom), 12'h00f,
			1'b1, 1'b0, 3'd0);
		end_test();

		step();
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			err_cnt);
		if (err_cnt == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire
